/* osc_top.f */
verilog/osc_pkg.sv
verilog/osc_trigger.sv
verilog/osc_acq.sv
verilog/osc_buffer.sv
verilog/osc_regs.sv
verilog/osc_top.sv
verification/osc_top_asserts.sv
verification/osc_top_tb.sv

/* verification/osc_top_asserts.sv */
// osc_top_asserts: bound checks on wishbone ack, stalled stream hold and capture reset
`default_nettype none

module osc_top_asserts (
  input logic              sti,
  input logic              ctl_rst,
  input logic              wb_cyc,
  input logic              wb_stb,
  input logic              wb_ack,
  input osc_pkg::smp_str_t smp_out,
  input logic              buf_rdy,
  input logic              sts_acq
);

  // one failure count per property
  int unsigned n_ack_cyc = 0;
  int unsigned n_ack_len = 0;
  int unsigned n_hold = 0;
  int unsigned n_rst = 0;
  int unsigned fails;

  assign fails = n_ack_cyc + n_ack_len + n_hold + n_rst;

  ////////////////////////////////////////
  // wishbone
  ////////////////////////////////////////

  // ack only inside an active cycle
  ack_in_cycle: assert property (@(posedge sti) disable iff (ctl_rst)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      n_ack_cyc++;
      $error("wb_ack high without cyc and stb");
    end

  // single cycle ack
  ack_one_cycle: assert property (@(posedge sti) disable iff (ctl_rst)
    wb_ack |=> !wb_ack)
    else begin
      n_ack_len++;
      $error("wb_ack lasted more than one cycle");
    end

  ////////////////////////////////////////
  // stream and reset
  ////////////////////////////////////////

  // stalled beat holds valid and data
  stall_hold: assert property (@(posedge sti) disable iff (ctl_rst)
    (smp_out.vld && !buf_rdy) |=> (smp_out.vld && $stable(smp_out.dat)))
    else begin
      n_hold++;
      $error("stalled smp_out changed");
    end

  rst_clears_acq: assert property (@(posedge sti) ctl_rst |=> !sts_acq)
    else begin
      n_rst++;
      $error("sts_acq high after ctl_rst");
    end

endmodule

bind osc_top osc_top_asserts osc_top_asserts_inst (
  .sti     (sti),
  .ctl_rst (ctl_rst),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .wb_ack  (wb_ack),
  .smp_out (smp_out),
  .buf_rdy (buf_rdy),
  .sts_acq (acq_sts.acq)
);

`default_nettype wire

/* verification/osc_top_tb.sv */
// directed testbench with clock, reset, wishbone and stream drivers, tests, watchdog
`default_nettype none

module osc_top_tb;

  import osc_pkg::*;

  // total samples over all tests sets the watchdog
  localparam int SMP_TOTAL = 125;
  localparam int WDOG_CYC = SMP_TOTAL * 20;

  logic              sti = 1'b0;
  logic              ctl_rst;
  smp_str_t          smp_in;
  logic              smp_rdy;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [WB_AW-1:0]  wb_adr;
  logic [WB_DW-1:0]  wb_dat_w;
  logic [WB_DW-1:0]  wb_dat_r;
  logic              wb_ack;

  int                errors;
  int                tests;
  int                failed_tests;
  int                stalls;
  int                bound_fails;
  // expected capture memory as signed sample values, and write pointer
  int                exp_mem [0:2**BUF_AW-1];
  int                exp_wptr;

  osc_top osc_top_inst (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .smp_in   (smp_in),
    .smp_rdy  (smp_rdy),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #50 sti = ~sti;

  ////////////////////////////////////////
  // bus and stream drivers
  ////////////////////////////////////////

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = dat;
    @(negedge sti);
    while (!wb_ack) @(negedge sti);
    // held through the edge that closes the ack cycle
    @(negedge sti);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    @(negedge sti);
    while (!wb_ack) @(negedge sti);
    dat = wb_dat_r;
    @(negedge sti);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // ramp from base by step or random values
  // only the first cap accepted samples land in memory
  task automatic send_samples(input int n, input int base, input int step, input bit rnd,
                              input bit lst_last, input int cap);
    int   i;
    int   s;
    logic acc;
    for (i = 0; i < n; i++) begin
      // random values span the whole signed sample range
      s = rnd ? int'($urandom % (2**SMP_W)) - 2**(SMP_W-1) : base + i * step;
      smp_in.vld = 1'b1;
      smp_in.lst = lst_last && (i == n - 1);
      smp_in.dat = SMP_W'(s);
      acc = 1'b0;
      while (!acc) begin
        // ready as seen by the transfer edge
        @(posedge sti);
        acc = smp_rdy;
        if (!acc) stalls++;
        @(negedge sti);
      end
      if (i < cap) begin
        exp_mem[BUF_AW'(exp_wptr)] = s;
        exp_wptr++;
      end
    end
    smp_in = '0;
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_word(input logic [WB_DW-1:0] got, input logic [WB_DW-1:0] exp,
                            input string what);
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] exp,
                           input string what);
    logic [WB_DW-1:0] d;
    wb_read(adr, d);
    check_word(d, exp, what);
  endtask

  // poll REG_CTL until a status bit takes a value
  task automatic wait_status(input int idx, input logic val, input string what);
    logic [WB_DW-1:0] d;
    int               n;
    n = 0;
    wb_read(REG_CTL, d);
    while (d[idx] !== val && n < 8) begin
      wb_read(REG_CTL, d);
      n++;
    end
    assert (d[idx] === val) else begin
      errors++;
      $display("%s did not happen within eight status reads", what);
    end
  endtask

  task automatic start_capture;
    wb_write(REG_CTL, WB_DW'(1) << CTL_ACQ);
    wait_status(0, 1'b1, "capture start");
  endtask

  task automatic soft_trigger;
    wb_write(REG_CTL, WB_DW'(1) << CTL_TRG);
    wait_status(1, 1'b1, "soft trigger");
  endtask

  // write pointer and then n memory words from address first on
  task automatic check_capture(input int first, input int n);
    int               i;
    logic [BUF_AW-1:0] a;
    logic [WB_DW-1:0] d;
    check_reg(REG_WPTR, WB_DW'(exp_wptr % (2**BUF_AW)), "write pointer");
    for (i = 0; i < n; i++) begin
      a = BUF_AW'(first + i);
      wb_read(BUF_BASE | WB_AW'(a), d);
      check_word(d, WB_DW'(exp_mem[a]), "capture memory");
    end
  endtask

  task automatic check_status_clear(input string what);
    int i;
    // lets a pending acquisition reset pulse land first
    @(negedge sti);
    check_reg(REG_CTL, '0, {what, ": status"});
    for (i = REG_STS_PRE; i <= REG_CTS_STP; i++) begin
      check_reg(WB_AW'(i), '0, {what, ": counter or timestamp"});
    end
  endtask

  task automatic report(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("%s: pass", name);
    end else begin
      failed_tests++;
      $display("%s: FAIL, %0d errors", name, errors - err0);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic soft_capture_test;
    int err0;
    int first;
    err0 = errors;
    first = exp_wptr;
    wb_write(REG_CFG, WB_DW'(1) << TRG_SOFT);
    wb_write(REG_PST, 32'd20);
    start_capture();
    send_samples(10, 100, 1, 0, 0, 10);
    soft_trigger();
    // only 20 post samples count and the last four come after the stop
    send_samples(24, 110, 1, 0, 0, 20);
    wait_status(0, 1'b0, "stop on post count");
    check_reg(REG_STS_PRE, 32'd10, "pre count");
    check_reg(REG_STS_PST, 32'd20, "post count");
    check_capture(first, 30);
    report("soft trigger capture", err0);
  endtask

  task automatic level_trigger_test;
    int               err0;
    int               first;
    logic [WB_DW-1:0] t_acq;
    logic [WB_DW-1:0] t_trg;
    logic [WB_DW-1:0] t_stp;
    err0 = errors;
    first = exp_wptr;
    wb_write(REG_CFG, WB_DW'(1) << TRG_RISE);
    wb_write(REG_LVL, 32'd0);
    wb_write(REG_PST, 32'd4);
    // idle sample below the level so the burst starts without a crossing
    send_samples(1, -100, 0, 0, 0, 0);
    start_capture();
    send_samples(5, -50, 10, 0, 0, 5);
    send_samples(1, 5, 0, 0, 0, 1);
    send_samples(4, 20, 1, 0, 0, 4);
    wait_status(0, 1'b0, "stop after level trigger");
    check_reg(REG_CTL, 32'h2, "rising trigger status");
    check_reg(REG_STS_PRE, 32'd6, "pre count through crossing");
    wb_read(REG_CTS_ACQ, t_acq);
    wb_read(REG_CTS_TRG, t_trg);
    wb_read(REG_CTS_STP, t_stp);
    assert (t_acq <= t_trg && t_trg <= t_stp) else begin
      errors++;
      $display("error at %0t: timestamps out of order %0d %0d %0d", $time, t_acq, t_trg, t_stp);
    end
    // same data against a falling-only mask
    wb_write(REG_CFG, WB_DW'(1) << TRG_FALL);
    send_samples(1, -100, 0, 0, 0, 0);
    start_capture();
    send_samples(5, -50, 10, 0, 0, 5);
    send_samples(1, 5, 0, 0, 0, 1);
    check_reg(REG_CTL, 32'h1, "falling mask stays untriggered");
    check_reg(REG_STS_PRE, 32'd6, "pre count without trigger");
    wb_write(REG_CTL, WB_DW'(1) << CTL_STP);
    wait_status(0, 1'b0, "stop command");
    check_capture(first, 16);
    report("level trigger", err0);
  endtask

  task automatic stop_conditions_test;
    int err0;
    int first;
    err0 = errors;
    first = exp_wptr;
    // continuous mode runs past cfg_pst
    wb_write(REG_CFG, (WB_DW'(1) << TRG_SOFT) | (WB_DW'(1) << CFG_CON));
    wb_write(REG_PST, 32'd3);
    start_capture();
    soft_trigger();
    send_samples(10, 300, 3, 0, 0, 10);
    check_reg(REG_CTL, 32'h3, "continuous capture running");
    wb_write(REG_CTL, WB_DW'(1) << CTL_STP);
    wait_status(0, 1'b0, "stop command");
    check_reg(REG_STS_PST, 32'd10, "continuous post count");
    // lst on the fifth beat
    wb_write(REG_CFG, WB_DW'(1) << TRG_SOFT);
    wb_write(REG_PST, 32'd100);
    start_capture();
    soft_trigger();
    send_samples(5, -7, -1, 0, 1, 5);
    wait_status(0, 1'b0, "stop on last beat");
    check_reg(REG_STS_PST, 32'd5, "post count up to last");
    // automatic mode starts triggered
    wb_write(REG_CFG, WB_DW'(1) << CFG_AUT);
    wb_write(REG_PST, 32'd8);
    start_capture();
    check_reg(REG_CTL, 32'h3, "automatic start triggered");
    send_samples(8, 1000, 10, 0, 0, 8);
    wait_status(0, 1'b0, "stop in automatic mode");
    check_reg(REG_STS_PRE, 32'd0, "automatic pre count");
    check_reg(REG_STS_PST, 32'd8, "automatic post count");
    check_capture(first, 23);
    report("stop conditions", err0);
  endtask

  task automatic backpressure_test;
    int               err0;
    int               first;
    int               i;
    logic [WB_DW-1:0] d;
    err0 = errors;
    first = exp_wptr;
    stalls = 0;
    wb_write(REG_CFG, WB_DW'(1) << TRG_SOFT);
    wb_write(REG_PST, 32'd40);
    start_capture();
    soft_trigger();
    fork
      send_samples(40, 0, 0, 1, 0, 40);
      begin
        // first capture words read while the stream is writing
        for (i = 0; i < 8; i++) begin
          wb_read(BUF_BASE | WB_AW'(i), d);
          check_word(d, WB_DW'(exp_mem[i]), "memory read under load");
        end
      end
    join
    wait_status(0, 1'b0, "stop after post count");
    assert (stalls > 0) else begin
      errors++;
      $display("memory reads never stalled the input stream");
    end
    check_capture(first, 40);
    report("back-pressure", err0);
  endtask

  task automatic reset_test;
    int err0;
    int first;
    err0 = errors;
    first = exp_wptr;
    wb_write(REG_CFG, WB_DW'(1) << TRG_SOFT);
    wb_write(REG_PST, 32'd50);
    start_capture();
    soft_trigger();
    send_samples(5, 2000, 1, 0, 0, 5);
    wb_write(REG_CTL, WB_DW'(1) << CTL_RST);
    check_status_clear("acquisition reset");
    // buffer keeps its pointer through the acquisition reset
    check_capture(first, 5);
    start_capture();
    soft_trigger();
    send_samples(5, 3000, 1, 0, 0, 5);
    ctl_rst = 1'b1;
    repeat (2) @(negedge sti);
    ctl_rst = 1'b0;
    exp_wptr = 0;
    check_status_clear("ctl_rst");
    check_reg(REG_WPTR, '0, "write pointer after reset");
    report("reset", err0);
  endtask

  task automatic register_test;
    int err0;
    err0 = errors;
    wb_write(REG_CFG, 32'hffff_ffff);
    wb_write(REG_LVL, WB_DW'(-300));
    wb_write(REG_PRE, 32'hdead_beef);
    wb_write(REG_PST, 32'h0123_4567);
    // only mask, continuous and automatic bits exist
    check_reg(REG_CFG, 32'h37, "config");
    check_reg(REG_LVL, 32'hffff_fed4, "trigger level");
    check_reg(REG_PRE, 32'hdead_beef, "pre config");
    check_reg(REG_PST, 32'h0123_4567, "post config");
    report("registers", err0);
  endtask

  ////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////

  initial begin
    void'($urandom(10));
    errors = 0;
    tests = 0;
    failed_tests = 0;
    stalls = 0;
    exp_wptr = 0;
    ctl_rst = 1'b1;
    smp_in = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (2) @(negedge sti);
    ctl_rst = 1'b0;
    soft_capture_test();
    level_trigger_test();
    stop_conditions_test();
    backpressure_test();
    reset_test();
    register_test();
    bound_fails = osc_top_inst.osc_top_asserts_inst.fails;
    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests, failed_tests, errors, bound_fails);
    if (errors == 0 && bound_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WDOG_CYC * 100);
    $display("timeout, the tests did not finish within %0d cycles", WDOG_CYC);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/osc_acq.sv */
// osc_acq: acquisition controller with stream gating, pre/post counters, event timestamps
`default_nettype none

module osc_acq (
  input  logic                         sti,
  input  logic                         ctl_rst,
  input  logic                         cmd_rst,
  // input stream
  input  osc_pkg::smp_str_t            smp_in,
  output logic                         smp_rdy,
  // output stream towards the capture memory
  output osc_pkg::smp_str_t            smp_out,
  input  logic                         buf_rdy,
  // current timestamp
  input  logic [osc_pkg::TS_W-1:0]     cts,
  // configuration and trigger sources
  input  osc_pkg::acq_cfg_t            cfg,
  input  logic [osc_pkg::TRG_NUM-1:0]  trg,
  // command pulses
  input  logic                         cmd_acq,
  input  logic                         cmd_stp,
  // status and timestamps
  output osc_pkg::acq_sts_t            sts
);

  ////////////////////////////////////////
  // stop and trigger decode
  ////////////////////////////////////////

  logic trn;
  logic trg_hit;
  logic stp_pst;
  logic stp;
  logic run;
  logic sts_rst;

  assign trn = smp_in.vld & smp_rdy;

  // any source enabled by the mask
  assign trg_hit = |(trg & cfg.trg);

  // post count reached, ignored in continuous mode
  assign stp_pst = sts.trg & (sts.pst == cfg.pst) & ~cfg.con;

  // stop on command, post count or a last beat
  assign stp = sts.acq & (cmd_stp | stp_pst | (trn & smp_in.lst));

  // counting and passing samples
  // a beat arriving once the post count is full is dropped
  assign run = sts.acq & ~stp_pst;

  // software acquisition reset acts like ctl_rst on status only
  assign sts_rst = ctl_rst | cmd_rst;

  ////////////////////////////////////////
  // status, counters, timestamps
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (sts_rst) begin
      sts <= '0;
    end else begin
      // start/stop
      if (stp) begin
        sts.acq     <= 1'b0;
        sts.cts_stp <= cts;
      end else if (cmd_acq) begin
        sts.acq     <= 1'b1;
        sts.cts_acq <= cts;
        // automatic mode starts already triggered
        sts.trg     <= cfg.aut;
        sts.pre     <= '0;
        sts.pst     <= '0;
      end
      // pre trigger: count and wait for a masked trigger
      if (run) begin
        if (!sts.trg) begin
          sts.pre <= sts.pre + trn;
          if (trg_hit) begin
            sts.trg     <= 1'b1;
            sts.cts_trg <= cts;
          end
        end else begin
          // post trigger
          sts.pst <= sts.pst + trn;
        end
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  logic                                out_vld;
  logic                                out_lst;
  logic signed [$bits(smp_in.dat)-1:0] out_dat;

  // free slot or the buffer takes the held beat this cycle
  assign smp_rdy = buf_rdy | ~out_vld;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      out_vld <= 1'b0;
      out_lst <= 1'b0;
    end else if (smp_rdy) begin
      out_vld <= run & smp_in.vld;
      out_lst <= run & smp_in.vld & smp_in.lst;
    end
  end

  // payload only moves when a slot opens
  always_ff @(posedge sti) begin
    if (smp_rdy & run) begin
      out_dat <= smp_in.dat;
    end
  end

  // field order vld, lst, dat
  assign smp_out = {out_vld, out_lst, out_dat};

endmodule

`default_nettype wire

/* verilog/osc_buffer.sv */
// osc_buffer: circular single-port capture memory with write pointer and stalling read port
`default_nettype none

module osc_buffer (
  input  logic                        sti,
  input  logic                        ctl_rst,
  // captured stream
  input  osc_pkg::smp_str_t           smp_out,
  output logic                        buf_rdy,
  // bus read port, one cycle latency
  input  logic                        rd_en,
  input  logic [osc_pkg::BUF_AW-1:0]  rd_adr,
  output logic [osc_pkg::SMP_W-1:0]   rd_dat,
  // next write location
  output logic [osc_pkg::BUF_AW-1:0]  wptr
);

  import osc_pkg::*;

  ////////////////////////////////////////
  // port arbitration
  ////////////////////////////////////////

  logic [SMP_W-1:0]  mem [0:2**BUF_AW-1];
  logic [BUF_AW-1:0] adr;
  logic              we;

  // bus read owns the port for its cycle
  assign buf_rdy = ~rd_en;

  // accepted beat
  assign we = smp_out.vld & buf_rdy;

  // single address for both directions
  assign adr = rd_en ? rd_adr : wptr;

  ////////////////////////////////////////
  // ram
  ////////////////////////////////////////

  // read first, data valid the cycle after rd_en
  always_ff @(posedge sti) begin
    if (we) begin
      mem[adr] <= smp_out.dat;
    end
    rd_dat <= mem[adr];
  end

  // write pointer
  // wraps at the top of the memory on its own
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      wptr <= '0;
    end else if (we) begin
      wptr <= wptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/osc_pkg.sv */
// osc_pkg: widths, register map, trigger indices and stream/config/status structs
`default_nettype none

package osc_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // adc sample, signed two's complement
  localparam int SMP_W = 14;
  // free-running timestamp
  localparam int TS_W = 32;
  // pre/post trigger counters
  localparam int CNT_W = 32;
  // capture memory depth is 2**BUF_AW
  localparam int BUF_AW = 8;
  // wishbone word address and data
  localparam int WB_AW = 9;
  localparam int WB_DW = 32;

  // trigger sources, bit positions in the trigger vector
  localparam int TRG_NUM = 3;
  localparam int TRG_RISE = 0;
  localparam int TRG_FALL = 1;
  localparam int TRG_SOFT = 2;

  ////////////////////////////////////////
  // register map, word addresses
  ////////////////////////////////////////

  localparam logic [WB_AW-1:0] REG_CTL = 9'd0;
  localparam logic [WB_AW-1:0] REG_CFG = 9'd1;
  localparam logic [WB_AW-1:0] REG_LVL = 9'd2;
  localparam logic [WB_AW-1:0] REG_PRE = 9'd3;
  localparam logic [WB_AW-1:0] REG_PST = 9'd4;
  // read only
  localparam logic [WB_AW-1:0] REG_STS_PRE = 9'd5;
  localparam logic [WB_AW-1:0] REG_STS_PST = 9'd6;
  localparam logic [WB_AW-1:0] REG_CTS_ACQ = 9'd7;
  localparam logic [WB_AW-1:0] REG_CTS_TRG = 9'd8;
  localparam logic [WB_AW-1:0] REG_CTS_STP = 9'd9;
  localparam logic [WB_AW-1:0] REG_WPTR = 9'd10;
  // capture memory window, upper half of the address space
  localparam logic [WB_AW-1:0] BUF_BASE = 9'd256;

  // REG_CTL write bits, all self-clearing
  localparam int CTL_ACQ = 0;
  localparam int CTL_STP = 1;
  localparam int CTL_TRG = 2;
  localparam int CTL_RST = 3;
  // REG_CFG mode bits, mask sits in bits TRG_NUM-1..0
  localparam int CFG_CON = 4;
  localparam int CFG_AUT = 5;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // sample stream beat, ready runs the other way on its own wire
  typedef struct packed {
    logic                    vld;
    logic                    lst;
    logic signed [SMP_W-1:0] dat;
  } smp_str_t;

  // acquisition configuration
  typedef struct packed {
    logic [TRG_NUM-1:0] trg;
    logic               con;
    logic               aut;
    logic [CNT_W-1:0]   pre;
    logic [CNT_W-1:0]   pst;
  } acq_cfg_t;

  // acquisition status and event timestamps
  typedef struct packed {
    logic             acq;
    logic             trg;
    logic [CNT_W-1:0] pre;
    logic [CNT_W-1:0] pst;
    logic [TS_W-1:0]  cts_acq;
    logic [TS_W-1:0]  cts_trg;
    logic [TS_W-1:0]  cts_stp;
  } acq_sts_t;

endpackage

`default_nettype wire

/* verilog/osc_regs.sv */
// osc_regs: wishbone classic slave with config, command pulses, timestamp counter and readback
`default_nettype none

module osc_regs (
  input  logic                             sti,
  input  logic                             ctl_rst,
  // wishbone classic slave
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [osc_pkg::WB_AW-1:0]        wb_adr,
  input  logic [osc_pkg::WB_DW-1:0]        wb_dat_w,
  output logic [osc_pkg::WB_DW-1:0]        wb_dat_r,
  output logic                             wb_ack,
  // configuration
  output osc_pkg::acq_cfg_t                cfg,
  output logic signed [osc_pkg::SMP_W-1:0] cfg_lvl,
  // status
  input  osc_pkg::acq_sts_t                sts,
  input  logic [osc_pkg::BUF_AW-1:0]       wptr,
  // one cycle commands
  output logic                             cmd_acq,
  output logic                             cmd_stp,
  output logic                             cmd_rst,
  output logic                             trg_soft,
  // timestamp
  output logic [osc_pkg::TS_W-1:0]         cts,
  // capture memory read port
  output logic                             buf_rd_en,
  output logic [osc_pkg::BUF_AW-1:0]       buf_rd_adr,
  input  logic [osc_pkg::SMP_W-1:0]        buf_rd_dat
);

  import osc_pkg::*;

  logic             req;
  logic             mem_sel;
  logic             mem_pend;
  logic             ctl_wr;
  logic [WB_DW-1:0] reg_dat;

  ////////////////////////////////////////
  // bus decode
  ////////////////////////////////////////

  // new access, not while acking or waiting on the ram
  assign req = wb_cyc & wb_stb & ~wb_ack & ~mem_pend;
  assign mem_sel = wb_adr >= BUF_BASE;

  // ram read in the first cycle of the access
  assign buf_rd_en = req & mem_sel & ~wb_we;
  assign buf_rd_adr = wb_adr[BUF_AW-1:0];

  // ctl write, master still holds data during ack
  assign ctl_wr = wb_ack & wb_we & (wb_adr == REG_CTL);

  // readback mux
  always_comb begin
    reg_dat = '0;
    case (wb_adr)
      REG_CTL: reg_dat[1:0] = {sts.trg, sts.acq};
      REG_CFG: begin
        reg_dat[TRG_NUM-1:0] = cfg.trg;
        reg_dat[CFG_CON] = cfg.con;
        reg_dat[CFG_AUT] = cfg.aut;
      end
      REG_LVL: reg_dat = WB_DW'(cfg_lvl);
      REG_PRE: reg_dat = cfg.pre;
      REG_PST: reg_dat = cfg.pst;
      REG_STS_PRE: reg_dat = sts.pre;
      REG_STS_PST: reg_dat = sts.pst;
      REG_CTS_ACQ: reg_dat = sts.cts_acq;
      REG_CTS_TRG: reg_dat = sts.cts_trg;
      REG_CTS_STP: reg_dat = sts.cts_stp;
      REG_WPTR: reg_dat[BUF_AW-1:0] = wptr;
      default: reg_dat = '0;
    endcase
  end

  ////////////////////////////////////////
  // ack and read data
  ////////////////////////////////////////

  // registers ack next cycle, memory one later
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      wb_ack   <= 1'b0;
      mem_pend <= 1'b0;
    end else begin
      wb_ack   <= (req & ~buf_rd_en) | mem_pend;
      mem_pend <= buf_rd_en;
    end
  end

  always_ff @(posedge sti) begin
    if (mem_pend) begin
      // sign extend the sample
      wb_dat_r <= {{(WB_DW-SMP_W){buf_rd_dat[SMP_W-1]}}, buf_rd_dat};
    end else if (req) begin
      wb_dat_r <= reg_dat;
    end
  end

  ////////////////////////////////////////
  // config, commands, timestamp
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cfg     <= '0;
      cfg_lvl <= '0;
    end else if (req & wb_we) begin
      case (wb_adr)
        REG_CFG: begin
          cfg.trg <= wb_dat_w[TRG_NUM-1:0];
          cfg.con <= wb_dat_w[CFG_CON];
          cfg.aut <= wb_dat_w[CFG_AUT];
        end
        REG_LVL: cfg_lvl <= wb_dat_w[SMP_W-1:0];
        REG_PRE: cfg.pre <= wb_dat_w;
        REG_PST: cfg.pst <= wb_dat_w;
        default: ;
      endcase
    end
  end

  // pulses land in the cycle after ack
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cmd_acq  <= 1'b0;
      cmd_stp  <= 1'b0;
      trg_soft <= 1'b0;
      cmd_rst  <= 1'b0;
    end else begin
      cmd_acq  <= ctl_wr & wb_dat_w[CTL_ACQ];
      cmd_stp  <= ctl_wr & wb_dat_w[CTL_STP];
      trg_soft <= ctl_wr & wb_dat_w[CTL_TRG];
      cmd_rst  <= ctl_wr & wb_dat_w[CTL_RST];
    end
  end

  // free running
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cts <= '0;
    end else begin
      cts <= cts + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/osc_top.sv */
// osc_top: capture subsystem top with trigger, acquisition, buffer and register blocks
`default_nettype none

module osc_top (
  input  logic                      sti,
  input  logic                      ctl_rst,
  // adc stream
  input  osc_pkg::smp_str_t         smp_in,
  output logic                      smp_rdy,
  // wishbone classic slave
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [osc_pkg::WB_AW-1:0] wb_adr,
  input  logic [osc_pkg::WB_DW-1:0] wb_dat_w,
  output logic [osc_pkg::WB_DW-1:0] wb_dat_r,
  output logic                      wb_ack
);

  import osc_pkg::*;

  ////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////

  acq_cfg_t                acq_cfg;
  acq_sts_t                acq_sts;
  smp_str_t                smp_out;
  logic                    buf_rdy;
  logic signed [SMP_W-1:0] cfg_lvl;
  logic [1:0]              trg_edge;
  logic                    trg_soft;
  logic [TRG_NUM-1:0]      osc_trg_vec;
  logic [TS_W-1:0]         cts;
  logic                    cmd_acq;
  logic                    cmd_stp;
  logic                    cmd_rst;
  logic                    buf_rd_en;
  logic [BUF_AW-1:0]       buf_rd_adr;
  logic [SMP_W-1:0]        buf_rd_dat;
  logic [BUF_AW-1:0]       wptr;

  // detector edges plus the software trigger
  assign osc_trg_vec[TRG_RISE] = trg_edge[TRG_RISE];
  assign osc_trg_vec[TRG_FALL] = trg_edge[TRG_FALL];
  assign osc_trg_vec[TRG_SOFT] = trg_soft;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  osc_trigger osc_trigger_inst (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .smp_in   (smp_in),
    .smp_rdy  (smp_rdy),
    .cfg_lvl  (cfg_lvl),
    .trg_edge (trg_edge)
  );

  osc_acq osc_acq_inst (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .cmd_rst (cmd_rst),
    .smp_in  (smp_in),
    .smp_rdy (smp_rdy),
    .smp_out (smp_out),
    .buf_rdy (buf_rdy),
    .cts     (cts),
    .cfg     (acq_cfg),
    .trg     (osc_trg_vec),
    .cmd_acq (cmd_acq),
    .cmd_stp (cmd_stp),
    .sts     (acq_sts)
  );

  osc_buffer osc_buffer_inst (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .smp_out (smp_out),
    .buf_rdy (buf_rdy),
    .rd_en   (buf_rd_en),
    .rd_adr  (buf_rd_adr),
    .rd_dat  (buf_rd_dat),
    .wptr    (wptr)
  );

  osc_regs osc_regs_inst (
    .sti        (sti),
    .ctl_rst    (ctl_rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .cfg        (acq_cfg),
    .cfg_lvl    (cfg_lvl),
    .sts        (acq_sts),
    .wptr       (wptr),
    .cmd_acq    (cmd_acq),
    .cmd_stp    (cmd_stp),
    .cmd_rst    (cmd_rst),
    .trg_soft   (trg_soft),
    .cts        (cts),
    .buf_rd_en  (buf_rd_en),
    .buf_rd_adr (buf_rd_adr),
    .buf_rd_dat (buf_rd_dat)
  );

endmodule

`default_nettype wire

/* verilog/osc_trigger.sv */
// osc_trigger: level-crossing detector giving rising and falling trigger pulses
`default_nettype none

module osc_trigger (
  input  logic                             sti,
  input  logic                             ctl_rst,
  // observed input stream
  input  osc_pkg::smp_str_t                smp_in,
  input  logic                             smp_rdy,
  // trigger level
  input  logic signed [osc_pkg::SMP_W-1:0] cfg_lvl,
  // crossing pulses, indexed by TRG_RISE/TRG_FALL
  output logic [1:0]                       trg_edge
);

  import osc_pkg::*;

  logic                    trn;
  logic                    prv_vld;
  logic                    prv_blw;
  logic                    cur_blw;
  logic signed [SMP_W-1:0] smp_prv;

  // transfer seen by the acquisition block in the same cycle
  assign trn = smp_in.vld & smp_rdy;

  // both compares signed against the current level
  assign prv_blw = smp_prv < cfg_lvl;
  assign cur_blw = $signed(smp_in.dat) < cfg_lvl;

  // rise: below -> at or above
  assign trg_edge[TRG_RISE] = trn & prv_vld & prv_blw & ~cur_blw;
  // fall: at or above -> below
  assign trg_edge[TRG_FALL] = trn & prv_vld & ~prv_blw & cur_blw;

  // no previous sample right after reset, so no edge on the first one
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      prv_vld <= 1'b0;
    end else if (trn) begin
      prv_vld <= 1'b1;
    end
  end

  // last transferred sample
  always_ff @(posedge sti) begin
    if (trn) begin
      smp_prv <= smp_in.dat;
    end
  end

endmodule

`default_nettype wire
